/* game_pkg.sv */
// Game timing and geometry; the defaults assume a 50 MHz clock, and each lane's x position is implied by its index
package game_pkg;

    // Lane layout, lanes 0-3 for player A and 4-7 for player B
    localparam int num_lanes        = 8;
    localparam int lanes_per_player = 4;

    // Playfield height in rows, an arrow expires on the tick after reaching it
    localparam int screen_height = 120;

    // Target window centre and half-width, rows 80 to 100
    localparam int target_y  = 90;
    localparam int hit_range = 10;

    // Arrow row, wide enough for the full screen height
    typedef logic [6:0] row_t;

    // One bit per lane, bit n for lane n
    typedef logic [num_lanes-1:0] lane_mask_t;

    // Power-on value of the pattern LFSR
    localparam logic [15:0] lfsr_seed = 16'hACE1;

    // Clock counts between spawns and between row steps
    localparam int spawn_interval_default = 25_000_000;
    localparam int move_interval_default  = 1_000_000;

    // Arrow direction, value equals the lane number modulo four
    typedef enum logic [1:0] {
        left  = 2'd0,
        up    = 2'd1,
        right = 2'd2,
        down  = 2'd3
    } direction_e;

endpackage

/* display_pkg.sv */
// Score range and active-low seven-segment codes for DE-series boards; digits above 9 have no code
package display_pkg;

    // Scores stop counting here
    localparam int score_max = 99;

    typedef logic [6:0] score_t;

    // Segment order gfedcba, a zero lights the segment
    typedef logic [6:0] seg_t;

    localparam seg_t digit_codes [0:9] = '{
        7'b1000000,  // 0
        7'b1111001,  // 1
        7'b0100100,  // 2
        7'b0110000,  // 3
        7'b0011001,  // 4
        7'b0010010,  // 5
        7'b0000010,  // 6
        7'b1111000,  // 7
        7'b0000000,  // 8
        7'b0010000   // 9
    };

endpackage

/* play_if.sv */
// Spawn and hit events as single-cycle strobes with no back-pressure; receivers act in the cycle they see them
`timescale 1ns/1ps

interface play_if
    import game_pkg::*;
();

    logic       spawn_valid;  // One cycle per spawn
    lane_mask_t spawn_lanes;  // Lanes to start, valid with spawn_valid
    logic       hit_a;        // Player A scored a hit
    logic       hit_b;        // Player B scored a hit

    modport generator (
        output spawn_valid,
        output spawn_lanes
    );

    modport field (
        input  spawn_valid,
        input  spawn_lanes,
        output hit_a,
        output hit_b
    );

    modport scorer (
        input hit_a,
        input hit_b
    );

endinterface

/* spawn_generator.sv */
// Spawns every spawn_interval+1 cycles while the game runs; both players always get the same pattern
`timescale 1ns/1ps

module spawn_generator
    import game_pkg::*;
#(
    parameter int spawn_interval = spawn_interval_default
) (
    input  logic      CLOCK_50,
    input  logic      reset,
    input  logic      game_active,
    play_if.generator play
);

    localparam int cnt_w = $clog2(spawn_interval + 1);
    localparam logic [cnt_w-1:0] spawn_last = cnt_w'(spawn_interval);

    logic [15:0]      lfsr;
    logic [cnt_w-1:0] spawn_cnt;
    logic             feedback;
    logic             spawn_now;

    // Map the low LFSR nibble onto one or two lane slots of a player
    function automatic logic [lanes_per_player-1:0] pattern_mask(input logic [3:0] sel);
        logic [lanes_per_player-1:0] m;
        m = '0;
        case (sel)
            4'd0:         m[up]    = 1'b1;
            4'd1:         m[down]  = 1'b1;
            4'd2:         m[left]  = 1'b1;
            4'd3:         m[right] = 1'b1;
            4'd4, 4'd5:   begin m[up]   = 1'b1; m[down]  = 1'b1; end
            4'd6, 4'd7:   begin m[up]   = 1'b1; m[left]  = 1'b1; end
            4'd8, 4'd9:   begin m[up]   = 1'b1; m[right] = 1'b1; end
            4'd10, 4'd11: begin m[down] = 1'b1; m[left]  = 1'b1; end
            4'd12, 4'd13: begin m[down] = 1'b1; m[right] = 1'b1; end
            default:      begin m[left] = 1'b1; m[right] = 1'b1; end
        endcase
        return m;
    endfunction

    assign feedback  = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
    assign spawn_now = game_active && (spawn_cnt == spawn_last);

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            spawn_cnt        <= '0;
            lfsr             <= lfsr_seed;
            play.spawn_valid <= 1'b0;
        end else if (spawn_now) begin
            spawn_cnt        <= '0;
            lfsr             <= {lfsr[14:0], feedback};  // Advance once per spawn
            play.spawn_valid <= 1'b1;
        end else begin
            spawn_cnt        <= game_active ? spawn_cnt + 1'b1 : '0;
            play.spawn_valid <= 1'b0;
        end
    end

    // Pattern taken from the value before the shift
    always_ff @(posedge CLOCK_50) begin
        if (spawn_now)
            play.spawn_lanes <= lane_mask_t'({2{pattern_mask(lfsr[3:0])}});
    end

endmodule

/* arrow_lane.sv */
// One falling arrow; the window flag is registered from the row, so a hit check sees the row one cycle late
`timescale 1ns/1ps

module arrow_lane
    import game_pkg::*;
(
    input  logic CLOCK_50,
    input  logic reset,
    input  logic game_active,
    input  logic spawn,
    input  logic move_tick,
    input  logic key,
    output logic active,
    output logic hit
);

    localparam row_t window_lo = row_t'(target_y - hit_range);
    localparam row_t window_hi = row_t'(target_y + hit_range);
    localparam row_t last_row  = row_t'(screen_height);

    row_t row;
    logic in_window;
    logic key_prev;

    // Rising key edge on a live arrow inside the window
    assign hit = game_active && key && !key_prev && active && in_window;

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            in_window <= 1'b0;
            key_prev  <= 1'b0;
        end else begin
            key_prev  <= key;
            in_window <= (row >= window_lo) && (row <= window_hi);
            if (!game_active)
                active <= 1'b0;             // Game stopped, drop the arrow
            else if (hit)
                active <= 1'b0;
            else if (move_tick && active && row >= last_row)
                active <= 1'b0;             // Fell off the bottom
            else if (spawn && !active)
                active <= 1'b1;
        end
    end

    // Row only matters while the arrow is live
    always_ff @(posedge CLOCK_50) begin
        if (spawn && !active)
            row <= '0;
        else if (move_tick && active && row < last_row)
            row <= row + 1'b1;
    end

endmodule

/* arrow_field.sv */
// Eight lanes stepped by one shared tick every move_interval+1 cycles; hits leave as one strobe per player
`timescale 1ns/1ps

module arrow_field
    import game_pkg::*;
#(
    parameter int move_interval = move_interval_default
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       game_active,
    input  logic [3:0] player_a_keys,
    input  logic [3:0] player_b_keys,
    play_if.field      play,
    output lane_mask_t lane_active
);

    localparam int cnt_w = $clog2(move_interval + 1);
    localparam logic [cnt_w-1:0] move_last = cnt_w'(move_interval);

    logic [cnt_w-1:0] move_cnt;
    logic             move_tick;
    lane_mask_t       lane_keys;
    lane_mask_t       lane_hit;

    assign move_tick = game_active && (move_cnt == move_last);
    assign lane_keys = {player_b_keys, player_a_keys};  // Player B in the upper half

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset)
            move_cnt <= '0;
        else if (!game_active || move_tick)
            move_cnt <= '0;
        else
            move_cnt <= move_cnt + 1'b1;
    end

    for (genvar n = 0; n < num_lanes; n++) begin : g_lane
        arrow_lane u_lane (
            .CLOCK_50   (CLOCK_50),
            .reset      (reset),
            .game_active(game_active),
            .spawn      (play.spawn_valid && play.spawn_lanes[n]),
            .move_tick  (move_tick),
            .key        (lane_keys[n]),
            .active     (lane_active[n]),
            .hit        (lane_hit[n])
        );
    end

    // Several lanes in one cycle still count once
    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            play.hit_a <= 1'b0;
            play.hit_b <= 1'b0;
        end else begin
            play.hit_a <= |lane_hit[lanes_per_player-1:0];
            play.hit_b <= |lane_hit[num_lanes-1:lanes_per_player];
        end
    end

endmodule

/* score_tracker.sv */
// Scores count only while the game runs and hold afterwards; win flags update only at game over
`timescale 1ns/1ps

module score_tracker
    import display_pkg::*;
(
    input  logic    CLOCK_50,
    input  logic    reset,
    input  logic    game_active,
    input  logic    show_game_over,
    play_if.scorer  play,
    output score_t  score_a,
    output score_t  score_b,
    output logic    player_a_won,
    output logic    player_b_won
);

    localparam score_t top_score = score_t'(score_max);

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            score_a      <= '0;
            score_b      <= '0;
            player_a_won <= 1'b0;
            player_b_won <= 1'b0;
        end else if (game_active) begin
            // Saturate at the top score
            if (play.hit_a && score_a < top_score)
                score_a <= score_a + 1'b1;
            if (play.hit_b && score_b < top_score)
                score_b <= score_b + 1'b1;

            player_a_won <= 1'b0;  // No winner mid-game
            player_b_won <= 1'b0;
        end else if (show_game_over) begin
            // A tie leaves both flags low
            player_a_won <= (score_a > score_b);
            player_b_won <= (score_b > score_a);
        end
    end

endmodule

/* score_display.sv */
// Two-digit decimal per player on active-low displays; scores above 99 are not decoded
`timescale 1ns/1ps

module score_display
    import display_pkg::*;
(
    input  logic   CLOCK_50,
    input  logic   reset,
    input  score_t score_a,
    input  score_t score_b,
    output seg_t   HEX0,
    output seg_t   HEX1,
    output seg_t   HEX2,
    output seg_t   HEX3
);

    logic [3:0] ones_a, tens_a;
    logic [3:0] ones_b, tens_b;

    always_comb begin
        ones_a = 4'(score_a % 10);
        tens_a = 4'(score_a / 10);
        ones_b = 4'(score_b % 10);
        tens_b = 4'(score_b / 10);
    end

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            HEX0 <= digit_codes[0];  // Show 00 00 out of reset
            HEX1 <= digit_codes[0];
            HEX2 <= digit_codes[0];
            HEX3 <= digit_codes[0];
        end else begin
            HEX0 <= digit_codes[ones_a];
            HEX1 <= digit_codes[tens_a];
            HEX2 <= digit_codes[ones_b];
            HEX3 <= digit_codes[tens_b];
        end
    end

endmodule

/* arrow_game_top.sv */
// Game logic only with no video output; lane_active and the hit strobes are meant for board LEDs
`timescale 1ns/1ps

module arrow_game_top
    import game_pkg::*;
#(
    parameter int spawn_interval = spawn_interval_default,
    parameter int move_interval  = move_interval_default
) (
    input  logic                 CLOCK_50,
    input  logic                 reset,
    input  logic                 game_active,
    input  logic                 show_game_over,
    input  logic [3:0]           player_a_keys,
    input  logic [3:0]           player_b_keys,
    output logic [6:0]           HEX0,
    output logic [6:0]           HEX1,
    output logic [6:0]           HEX2,
    output logic [6:0]           HEX3,
    output logic [num_lanes-1:0] lane_active,
    output logic                 hit_a,
    output logic                 hit_b,
    output logic                 player_a_won,
    output logic                 player_b_won
);

    logic [6:0] score_a;
    logic [6:0] score_b;

    play_if u_play ();

    assign hit_a = u_play.hit_a;
    assign hit_b = u_play.hit_b;

    spawn_generator #(
        .spawn_interval(spawn_interval)
    ) u_spawn (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .game_active(game_active),
        .play       (u_play.generator)
    );

    arrow_field #(
        .move_interval(move_interval)
    ) u_field (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .game_active  (game_active),
        .player_a_keys(player_a_keys),
        .player_b_keys(player_b_keys),
        .play         (u_play.field),
        .lane_active  (lane_active)
    );

    score_tracker u_score (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .game_active   (game_active),
        .show_game_over(show_game_over),
        .play          (u_play.scorer),
        .score_a       (score_a),
        .score_b       (score_b),
        .player_a_won  (player_a_won),
        .player_b_won  (player_b_won)
    );

    // HEX1:HEX0 for player A, HEX3:HEX2 for player B
    score_display u_display (
        .CLOCK_50(CLOCK_50),
        .reset   (reset),
        .score_a (score_a),
        .score_b (score_b),
        .HEX0    (HEX0),
        .HEX1    (HEX1),
        .HEX2    (HEX2),
        .HEX3    (HEX3)
    );

endmodule

/* tb_arrow_game.sv */
// Runs the steps from game_input.txt with fast intervals, then two long key-toggling runs for saturation
`timescale 1ns/1ps

module tb_arrow_game;

    localparam int max_steps  = 64;
    localparam int sat_cycles = 12000;  // Far more hits than needed to reach 99
    localparam int margin     = 200;

    logic       CLOCK_50;
    logic       reset;
    logic       game_active;
    logic       show_game_over;
    logic [3:0] player_a_keys;
    logic [3:0] player_b_keys;
    logic [6:0] HEX0, HEX1, HEX2, HEX3;
    logic [7:0] lane_active;
    logic       hit_a, hit_b;
    logic       player_a_won, player_b_won;

    logic [63:0] steps [0:max_steps-1];
    int          num_steps;
    int          errors;
    int          cycle_count;
    int          cycle_limit;
    int          hit_a_pulses;
    int          hit_b_pulses;
    int          last_score_a;
    int          last_score_b;

    arrow_game_top #(
        .spawn_interval(15),
        .move_interval (1)
    ) u_dut (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .game_active   (game_active),
        .show_game_over(show_game_over),
        .player_a_keys (player_a_keys),
        .player_b_keys (player_b_keys),
        .HEX0          (HEX0),
        .HEX1          (HEX1),
        .HEX2          (HEX2),
        .HEX3          (HEX3),
        .lane_active   (lane_active),
        .hit_a         (hit_a),
        .hit_b         (hit_b),
        .player_a_won  (player_a_won),
        .player_b_won  (player_b_won)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // Active-low gfedcba, returns 99 for a pattern that is no digit
    function automatic int seg_to_digit(input logic [6:0] seg);
        case (seg)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return 99;
        endcase
    endfunction

    function automatic int shown_score(input logic [6:0] tens, input logic [6:0] ones);
        return seg_to_digit(tens) * 10 + seg_to_digit(ones);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Keys of the chosen players toggle every cycle, then the game stops and shows game over
    task automatic hammer_keys(input logic press_a, input logic press_b);
        game_active    = 1'b1;
        show_game_over = 1'b0;
        for (int i = 0; i < sat_cycles; i++) begin
            player_a_keys = (press_a && i[0]) ? 4'hF : 4'h0;
            player_b_keys = (press_b && i[0]) ? 4'hF : 4'h0;
            @(posedge CLOCK_50);
            @(negedge CLOCK_50);
        end
        player_a_keys = 4'h0;
        player_b_keys = 4'h0;
        game_active   = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        show_game_over = 1'b1;
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
    endtask

    // Final scores and flags once the game is over and the lanes are empty
    task automatic check_outcome(input int exp_a, input int exp_b, input int won_a,
                                 input int won_b);
        check_value("score_a", exp_a, shown_score(HEX1, HEX0));
        check_value("score_b", exp_b, shown_score(HEX3, HEX2));
        check_value("lane_active", 0, lane_active);
        check_value("player_a_won", won_a, player_a_won);
        check_value("player_b_won", won_b, player_b_won);
    endtask

    // Strobes counted once per high cycle
    always @(negedge CLOCK_50) begin
        if (hit_a)
            hit_a_pulses++;
        if (hit_b)
            hit_b_pulses++;
    end

    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        errors         = 0;
        cycle_count    = 0;
        hit_a_pulses   = 0;
        hit_b_pulses   = 0;
        last_score_a   = 0;
        last_score_b   = 0;
        reset          = 1'b1;
        game_active    = 1'b0;
        show_game_over = 1'b0;
        player_a_keys  = 4'h0;
        player_b_keys  = 4'h0;

        for (int i = 0; i < max_steps; i++)
            steps[i] = '0;
        $readmemh("game_input.txt", steps);
        num_steps   = 0;
        cycle_limit = 3 + 2 * sat_cycles + margin;
        while (num_steps < max_steps && steps[num_steps][63:48] != 0) begin
            cycle_limit += steps[num_steps][63:48] + 1;
            num_steps++;
        end
        if (num_steps == 0) begin
            $display("No steps could be read from game_input.txt");
            errors++;
        end

        repeat (3) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        reset = 1'b0;

        for (int s = 0; s < num_steps; s++) begin
            player_a_keys  = steps[s][47:44];
            player_b_keys  = steps[s][43:40];
            game_active    = steps[s][36];
            show_game_over = steps[s][32];
            repeat (steps[s][63:48]) @(posedge CLOCK_50);
            @(negedge CLOCK_50);
            last_score_a = steps[s][31:24];
            last_score_b = steps[s][23:16];
            check_value("score_a", last_score_a, shown_score(HEX1, HEX0));
            check_value("score_b", last_score_b, shown_score(HEX3, HEX2));
            check_value("lane_active", steps[s][15:8], lane_active);
            check_value("player_a_won", steps[s][4], player_a_won);
            check_value("player_b_won", steps[s][0], player_b_won);
        end

        // One strobe per point scored
        check_value("hit_a pulses", last_score_a, hit_a_pulses);
        check_value("hit_b pulses", last_score_b, hit_b_pulses);

        // Player B alone presses, reaches the top score and wins
        hammer_keys(1'b0, 1'b1);
        check_outcome(last_score_a, 99, 0, 1);

        // Both press, B stays at the top score and A catches up for a tie
        hammer_keys(1'b1, 1'b1);
        check_outcome(99, 99, 0, 0);

        $display("Checks done with %0d errors", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* game_input.txt */
// cccc_kk_ag_sa_sb_ll_ww: cycles, keys A/B, active/game over, scores A/B, lane_active, won A/B
// All fields hex; a step drives on a falling edge, waits cccc rising edges, then checks
0001_00_00_00_00_00_00
0011_00_10_00_00_88_00
0010_00_10_00_00_CC_00
0010_00_10_00_00_FF_00
0032_80_10_00_00_FF_00
0064_00_10_00_00_FF_00
0003_80_10_01_00_F7_00
0037_00_10_01_00_FF_00
0001_00_10_01_00_7F_00
0010_00_10_01_00_3B_00
0002_00_00_01_00_00_00
0002_00_01_01_00_00_10
0002_00_00_01_00_00_10

/* verilog.f */
game_pkg.sv
display_pkg.sv
play_if.sv
spawn_generator.sv
arrow_lane.sv
arrow_field.sv
score_tracker.sv
score_display.sv
arrow_game_top.sv
tb_arrow_game.sv

/* Bender.yml */
package:
  name: arrow_game

sources:
  - game_pkg.sv
  - display_pkg.sv
  - play_if.sv
  - spawn_generator.sv
  - arrow_lane.sv
  - arrow_field.sv
  - score_tracker.sv
  - score_display.sv
  - arrow_game_top.sv
  - target: simulation
    files:
      - tb_arrow_game.sv
